//--- bench/exec_pipe_tb.sv
// testbench for the execute pipeline that replays the testdata records and checks each writeback
`default_nettype none

`include "pipe_macros.svh"

module exec_pipe_tb
    import rv_word_pkg::*;
    import pipe_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_REC = 64;  // record storage depth

    logic      i_clk, i_rst_n, i_issue;
    alu_op_e   i_op;
    reg_addr_t i_rs1_addr, i_rs2_addr, i_rd_addr;
    word_t     i_load_data;
    logic      o_issue_ready, o_wb_valid;
    reg_addr_t o_wb_rd_addr;
    word_t     o_wb_data;

    logic [3:0] rec_test [MAX_REC];  // test number per record
    logic [2:0] rec_op [MAX_REC];
    reg_addr_t  rec_rs1 [MAX_REC], rec_rs2 [MAX_REC], rec_rd [MAX_REC];
    word_t      rec_ld [MAX_REC], rec_exp [MAX_REC];
    int         n_rec;
    word_t      model_regs [`PIPE_NREGS];  // reference register state in issue order
    word_t      exp_data_q [$];            // outstanding writebacks with the oldest first
    reg_addr_t  exp_addr_q [$];
    int         err_count, wb_count, tests_run, tests_failed;
    int         cycles, cycle_limit = 100000;
    int         low_run, low_max;          // longest stretch of issue ready low
    int         seed = 18;

    exec_pipe_top dut_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (i_issue),
        .i_op          (i_op),
        .i_rs1_addr    (i_rs1_addr),
        .i_rs2_addr    (i_rs2_addr),
        .i_rd_addr     (i_rd_addr),
        .i_load_data   (i_load_data),
        .o_issue_ready (o_issue_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd_addr  (o_wb_rd_addr),
        .o_wb_data     (o_wb_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;  // 40 ns period
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, writebacks still outstanding", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(negedge i_clk) begin
        if (!i_rst_n || o_issue_ready) begin
            low_run = 0;
        end else begin
            low_run++;
            if (low_run > low_max) low_max = low_run;
        end
    end

    always @(negedge i_clk) begin
        if (i_rst_n && o_wb_valid) check_writeback();  // registered outputs are stable here
    end

    function automatic word_t model_exec(input alu_op_e op, input word_t a, input word_t b,
                                         input word_t ld);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_AND:  return a & b;
            default: return ld;  // load just returns its datum
        endcase
    endfunction

    task automatic check_writeback();
        word_t     exp_data;
        reg_addr_t exp_addr;
        wb_count++;
        assert (exp_data_q.size() > 0) else begin
            $display("writeback at %0t with no instruction outstanding", $realtime);
            err_count++;
        end
        if (exp_data_q.size() > 0) begin
            exp_data = exp_data_q.pop_front();
            exp_addr = exp_addr_q.pop_front();
            assert (o_wb_data == exp_data) else begin
                $display("** Error at %0t: o_wb_data = %h, expected %h",
                         $realtime, o_wb_data, exp_data);
                err_count++;
            end
            assert (o_wb_rd_addr == exp_addr) else begin
                $display("** Error at %0t: o_wb_rd_addr = %h, expected %h",
                         $realtime, o_wb_rd_addr, exp_addr);
                err_count++;
            end
        end
    endtask

    // model the record, queue its writeback, then strobe it in on a falling edge
    task automatic issue_record(input int idx);
        word_t a, b, res;
        a = (rec_rs1[idx] == '0) ? '0 : model_regs[rec_rs1[idx]];  // x0 reads zero
        b = (rec_rs2[idx] == '0) ? '0 : model_regs[rec_rs2[idx]];
        res = model_exec(alu_op_e'(rec_op[idx]), a, b, rec_ld[idx]);
        if (rec_rd[idx] == '0) res = '0;  // x0 writeback carries 0
        else model_regs[rec_rd[idx]] = res;
        assert (res == rec_exp[idx]) else begin
            $display("** Error at %0t: record %0d expect = %h, model %h",
                     $realtime, idx, rec_exp[idx], res);
            err_count++;
        end
        exp_data_q.push_back(res);
        exp_addr_q.push_back(rec_rd[idx]);
        while (!o_issue_ready) @(negedge i_clk);  // pipeline holding off issue
        i_issue     = 1'b1;
        i_op        = alu_op_e'(rec_op[idx]);
        i_rs1_addr  = rec_rs1[idx];
        i_rs2_addr  = rec_rs2[idx];
        i_rd_addr   = rec_rd[idx];
        i_load_data = rec_ld[idx];
        @(negedge i_clk);
        i_issue = 1'b0;
    endtask

    task automatic drain_pipe();
        while (exp_data_q.size() > 0) @(negedge i_clk);
        repeat (2) @(negedge i_clk);  // room for a stray extra pulse
    endtask

    task automatic report_test(input int num, input int first_err);
        tests_run++;
        if (err_count == first_err) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed, %0d errors", num, err_count - first_err);
            tests_failed++;
        end
    endtask

    initial begin : run_tests
        int          fd, code, idx, t_cur, t_err0, gap;
        string       line;
        logic [31:0] f_test, f_op, f_rs1, f_rs2, f_rd, f_ld, f_exp;
        $timeformat(-9, 1, " ns", 0);
        i_rst_n     = 1'b0;
        i_issue     = 1'b0;
        i_op        = OP_ADD;
        i_rs1_addr  = '0;
        i_rs2_addr  = '0;
        i_rd_addr   = '0;
        i_load_data = '0;
        for (int r = 0; r < `PIPE_NREGS; r++) model_regs[r] = '0;

        fd = $fopen("bench/exec_pipe_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/exec_pipe_testdata.txt");
            $display("Finished with errors");
            $finish;
        end
        n_rec = 0;
        while (!$feof(fd) && n_rec < MAX_REC) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin  // skip header lines
                code = $sscanf(line, "%h %h %h %h %h %h %h",
                               f_test, f_op, f_rs1, f_rs2, f_rd, f_ld, f_exp);
                if (code == 7) begin
                    rec_test[n_rec] = f_test[3:0];
                    rec_op[n_rec]   = f_op[2:0];
                    rec_rs1[n_rec]  = f_rs1[`PIPE_REG_AW-1:0];
                    rec_rs2[n_rec]  = f_rs2[`PIPE_REG_AW-1:0];
                    rec_rd[n_rec]   = f_rd[`PIPE_REG_AW-1:0];
                    rec_ld[n_rec]   = f_ld;
                    rec_exp[n_rec]  = f_exp;
                    n_rec++;
                end
            end
        end
        $fclose(fd);
        cycle_limit = n_rec * (`PIPE_LOAD_LAT + 6) + 50;  // worst case per record plus margin

        // test 1 checks reset state and first issue ready
        t_err0 = err_count;
        repeat (3) begin
            @(negedge i_clk);
            assert (!o_issue_ready && !o_wb_valid) else begin
                $display("** Error at %0t: o_issue_ready = %b, o_wb_valid = %b, expected 0 0",
                         $realtime, o_issue_ready, o_wb_valid);
                err_count++;
            end
        end
        i_rst_n = 1'b1;
        @(negedge i_clk);
        assert (o_issue_ready) else begin
            $display("** Error at %0t: o_issue_ready = 0, expected 1", $realtime);
            err_count++;
        end
        report_test(1, t_err0);

        idx = 0;
        while (idx < n_rec) begin
            t_cur  = rec_test[idx];
            t_err0 = err_count;
            low_max = 0;
            while (idx < n_rec && rec_test[idx] == t_cur) begin
                if (t_cur == 6) begin
                    gap = $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
                    repeat (gap) @(negedge i_clk);
                end
                issue_record(idx);
                idx++;
            end
            drain_pipe();
            if (t_cur == 4) begin
                // a consumer waits past the plain load latency until the load reaches writeback
                assert (low_max > `PIPE_LOAD_LAT) else begin
                    $display("load-use stall held issue off for only %0d cycles, expected over %0d",
                             low_max, `PIPE_LOAD_LAT);
                    err_count++;
                end
            end
            report_test(t_cur, t_err0);
        end

        assert (wb_count == n_rec) else begin
            $display("saw %0d writebacks for %0d issued records", wb_count, n_rec);
            err_count++;
        end
        $display("%0d tests, %0d failed, %0d writebacks, %0d errors",
                 tests_run, tests_failed, wb_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/exec_pipe_testdata.txt
# test op rs1 rs2 rd load_data expect, all hex
# op 0 add, 1 sub, 2 xor, 3 and, 4 load, expect is the writeback value
2 4 00 00 01 12345678 12345678
2 4 00 00 02 0000ffff 0000ffff
2 4 00 00 03 80000001 80000001
2 4 00 00 04 0f0f0f0f 0f0f0f0f
2 0 01 02 05 00000000 12355677
2 1 03 04 06 00000000 70f0f0f2
2 2 01 04 07 00000000 1d3b5977
2 3 02 03 08 00000000 00000001
3 0 05 01 09 00000000 2469acef
3 2 09 06 0a 00000000 54995c1d
3 1 09 0a 0b 00000000 cfd050d2
3 0 01 01 0c 00000000 2468acf0
3 2 0c 02 0c 00000000 2468530f
3 3 0c 0c 0d 00000000 2468530f
4 4 00 00 0f 000000a5 000000a5
4 0 0f 01 10 00000000 1234571d
4 4 00 00 11 fffffff0 fffffff0
4 1 02 11 12 00000000 0001000f
4 4 00 00 13 00000003 00000003
4 3 13 13 14 00000000 00000003
5 0 00 01 15 00000000 12345678
5 0 01 02 00 00000000 00000000
5 0 00 00 16 00000000 00000000
5 4 00 00 00 deadbeef 00000000
5 2 00 03 17 00000000 80000001
6 4 00 00 18 00000100 00000100
6 0 18 18 19 00000000 00000200
6 1 19 18 1a 00000000 00000100
6 2 1a 04 1b 00000000 0f0f0e0f
6 3 1b 07 1c 00000000 0d0b0807
6 4 00 00 1d 7fffffff 7fffffff
6 0 1d 1d 1e 00000000 fffffffe
6 0 1e 03 1f 00000000 7fffffff

//--- include/pipe_macros.svh
// widths and load latency for the execute pipeline, included by the packages and the RTL that sizes on them
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

`define PIPE_XLEN     32  // data word width
`define PIPE_REG_AW   5   // register address width
`define PIPE_NREGS    32  // architectural register count

// extra cycles a load spends in memory access, legal range 1..7 (fits lat_cnt_t)
`define PIPE_LOAD_LAT 3

`endif

//--- tb.f
+incdir+include
verilog/rv_word_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/base_regfile.sv
verilog/operand_forwarding.sv
verilog/alu_stage.sv
verilog/load_wait_timer.sv
verilog/pipe_ctrl_fsm.sv
verilog/exec_pipe_top.sv
bench/exec_pipe_tb.sv

//--- verilog/alu_stage.sv
// ALU-stage instruction registers, the ALU itself and the memory-access stage register
`default_nettype none

module alu_stage
    import rv_word_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  wire       i_alu_ce,        // capture issue, push ALU result to memory access
    input  wire       i_mem_ce,        // memory access drains to writeback
    input  wire       i_issue,
    input  alu_op_e   i_op,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_rd_addr,
    input  word_t     i_load_data,
    input  word_t     i_rs1,           // forwarded operands
    input  word_t     i_rs2,
    output reg_addr_t o_rs1_addr_q,
    output reg_addr_t o_rs2_addr_q,
    output alu_op_e   o_op_q,
    output logic      o_alu_valid,
    output logic      o_mem_valid,
    output logic      o_mem_wr_rd,
    output logic      o_mem_rd_valid,
    output reg_addr_t o_mem_rd_addr,
    output word_t     o_mem_rd
);

    reg_addr_t rd_addr_q;    // ALU-stage destination
    word_t     load_data_q;  // datum carried by a load
    word_t     alu_result;

    always_comb begin
        case (o_op_q)
            OP_ADD:  alu_result = i_rs1 + i_rs2;
            OP_SUB:  alu_result = i_rs1 - i_rs2;
            OP_XOR:  alu_result = i_rs1 ^ i_rs2;
            OP_AND:  alu_result = i_rs1 & i_rs2;
            OP_LOAD: alu_result = load_data_q;  // passes through untouched
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_alu_valid    <= 1'b0;
            o_mem_valid    <= 1'b0;
            o_mem_wr_rd    <= 1'b0;
            o_mem_rd_valid <= 1'b0;
        end else if (i_alu_ce) begin
            o_alu_valid    <= i_issue;                 // bubble when nothing issued
            o_mem_valid    <= o_alu_valid;
            o_mem_wr_rd    <= (rd_addr_q != '0);
            o_mem_rd_valid <= (o_op_q != OP_LOAD);     // load value is late
        end else if (i_mem_ce) begin
            o_mem_valid    <= 1'b0;  // drained while ALU holds, leave a bubble
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_alu_ce) begin
            o_op_q        <= i_op;
            o_rs1_addr_q  <= i_rs1_addr;
            o_rs2_addr_q  <= i_rs2_addr;
            rd_addr_q     <= i_rd_addr;
            load_data_q   <= i_load_data;
            o_mem_rd_addr <= rd_addr_q;
            o_mem_rd      <= (rd_addr_q == '0) ? '0 : alu_result;  // x0 writes back 0
        end
    end

endmodule

`default_nettype wire

//--- verilog/base_regfile.sv
// architectural register file with two combinational read ports and one clocked write port
`default_nettype none

`include "pipe_macros.svh"

module base_regfile
    import rv_word_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  reg_addr_t i_rs1_addr,  // ALU-stage source 1
    input  reg_addr_t i_rs2_addr,  // ALU-stage source 2
    input  wire       i_wr_en,     // writeback strobe already low for rd zero
    input  reg_addr_t i_wr_addr,
    input  word_t     i_wr_data,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs_q [`PIPE_NREGS];  // register storage

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                regs_q[i] <= '0;  // all registers start at zero
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs_q[i_wr_addr] <= i_wr_data;  // x0 writes are dropped
        end
    end

    assign o_rs1_data = regs_q[i_rs1_addr];  // no internal bypass as forwarding covers it
    assign o_rs2_data = regs_q[i_rs2_addr];

    // the writeback stage never strobes a write to x0
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_en |-> (i_wr_addr != '0))
        else $error("regfile: write strobe raised for x0");

endmodule

`default_nettype wire

//--- verilog/exec_pipe_top.sv
// top level of the three-stage execute pipeline, connects register file, forwarding, stages and control
`default_nettype none

module exec_pipe_top
    import rv_word_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  wire       i_issue,        // strobe, legal only while o_issue_ready is high
    input  alu_op_e   i_op,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_rd_addr,
    input  word_t     i_load_data,
    output logic      o_issue_ready,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd_addr,
    output word_t     o_wb_data
);

    logic      alu_ce, mem_ce;           // stage advance enables
    logic      alu_valid, mem_valid;     // stage occupancy
    logic      mem_wr_rd, mem_rd_valid;
    reg_addr_t mem_rd_addr;
    word_t     mem_rd;
    logic      wb_wr_rd;
    logic      lat_start, lat_done;
    logic      alu_force_stall;
    reg_addr_t rs1_addr_q, rs2_addr_q;   // ALU-stage sources
    word_t     rs1_orig, rs2_orig;       // register file read data
    word_t     rs1_fwd, rs2_fwd;         // forwarded operands

    base_regfile regfile_i (
        .i_clk      (i_clk),        .i_rst_n    (i_rst_n),
        .i_rs1_addr (rs1_addr_q),   .i_rs2_addr (rs2_addr_q),
        .i_wr_en    (wb_wr_rd),     .i_wr_addr  (o_wb_rd_addr),
        .i_wr_data  (o_wb_data),
        .o_rs1_data (rs1_orig),     .o_rs2_data (rs2_orig)
    );

    operand_forwarding fwd_i (
        .i_clk          (i_clk),        .i_rst_n        (i_rst_n),
        .i_rs1_orig     (rs1_orig),     .i_rs2_orig     (rs2_orig),
        .i_rs1_addr_q   (rs1_addr_q),   .i_rs2_addr_q   (rs2_addr_q),
        .i_mem_valid    (mem_valid),    .i_mem_wr_rd    (mem_wr_rd),
        .i_mem_rd_valid (mem_rd_valid), .i_mem_rd_addr  (mem_rd_addr),
        .i_mem_rd       (mem_rd),
        .i_wb_valid     (o_wb_valid),   .i_wb_wr_rd     (wb_wr_rd),
        .i_wb_rd_addr   (o_wb_rd_addr), .i_wb_rd        (o_wb_data),
        .o_rs1          (rs1_fwd),      .o_rs2          (rs2_fwd),
        .o_alu_force_stall (alu_force_stall)
    );

    alu_stage alu_i (
        .i_clk        (i_clk),        .i_rst_n      (i_rst_n),
        .i_alu_ce     (alu_ce),       .i_mem_ce     (mem_ce),
        .i_issue      (i_issue),      .i_op         (i_op),
        .i_rs1_addr   (i_rs1_addr),   .i_rs2_addr   (i_rs2_addr),
        .i_rd_addr    (i_rd_addr),    .i_load_data  (i_load_data),
        .i_rs1        (rs1_fwd),      .i_rs2        (rs2_fwd),
        .o_rs1_addr_q (rs1_addr_q),   .o_rs2_addr_q (rs2_addr_q),
        .o_op_q       (),             .o_alu_valid  (alu_valid),
        .o_mem_valid  (mem_valid),    .o_mem_wr_rd  (mem_wr_rd),
        .o_mem_rd_valid (mem_rd_valid),
        .o_mem_rd_addr  (mem_rd_addr),
        .o_mem_rd     (mem_rd)
    );

    load_wait_timer timer_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_start (lat_start), .o_busy (), .o_done (lat_done)
    );

    pipe_ctrl_fsm ctrl_i (
        .i_clk          (i_clk),        .i_rst_n        (i_rst_n),
        .i_alu_valid    (alu_valid),    .i_mem_valid    (mem_valid),
        .i_mem_wr_rd    (mem_wr_rd),    .i_mem_rd_valid (mem_rd_valid),
        .i_mem_rd_addr  (mem_rd_addr),  .i_mem_rd       (mem_rd),
        .i_alu_force_stall (alu_force_stall),
        .i_lat_done     (lat_done),
        .o_alu_ce       (alu_ce),       .o_mem_ce       (mem_ce),
        .o_lat_start    (lat_start),    .o_issue_ready  (o_issue_ready),
        .o_wb_valid     (o_wb_valid),   .o_wb_wr_rd     (wb_wr_rd),
        .o_wb_rd_addr   (o_wb_rd_addr), .o_wb_rd        (o_wb_data)
    );

endmodule

`default_nettype wire

//--- verilog/load_wait_timer.sv
// down counter that holds a load in memory access and pulses done after the load latency
`default_nettype none

`include "pipe_macros.svh"

module load_wait_timer
    import rv_word_pkg::*;
(
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_start,  // one-cycle pulse from the FSM
    output logic o_busy,
    output logic o_done    // high in the last counted cycle
);

    lat_cnt_t cnt_q;  // remaining wait cycles

    assign o_busy = (cnt_q != '0);
    assign o_done = (cnt_q == lat_cnt_t'(1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_start) begin
            cnt_q <= lat_cnt_t'(`PIPE_LOAD_LAT);  // done lands LOAD_LAT cycles later
        end else if (o_busy) begin
            cnt_q <= cnt_q - lat_cnt_t'(1);
        end
    end

    // only one load can wait at a time
    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !o_busy)
        else $error("load timer: start while busy");

endmodule

`default_nettype wire

//--- verilog/operand_forwarding.sv
// corrects the ALU operands from the memory-access and writeback stages and flags load-use stalls
`default_nettype none

module operand_forwarding
    import rv_word_pkg::*;
(
    input  wire       i_clk,           // sampling clock for the checker only
    input  wire       i_rst_n,
    input  word_t     i_rs1_orig,      // rs1 as read from the register file
    input  word_t     i_rs2_orig,      // rs2 as read from the register file
    input  reg_addr_t i_rs1_addr_q,    // source addresses held in the ALU stage
    input  reg_addr_t i_rs2_addr_q,
    // memory-access stage
    input  wire       i_mem_valid,     // stage holds an instruction
    input  wire       i_mem_wr_rd,     // rd will be written
    input  wire       i_mem_rd_valid,  // low while the entry is a pending load
    input  reg_addr_t i_mem_rd_addr,
    input  word_t     i_mem_rd,
    // writeback stage
    input  wire       i_wb_valid,
    input  wire       i_wb_wr_rd,
    input  reg_addr_t i_wb_rd_addr,
    input  word_t     i_wb_rd,
    output word_t     o_rs1,           // forwarded operands
    output word_t     o_rs2,
    output logic      o_alu_force_stall
);

    logic rs1_mem_hit, rs2_mem_hit;  // match against memory access
    logic rs1_wb_hit, rs2_wb_hit;    // match against writeback

    assign rs1_mem_hit = i_mem_valid && i_mem_wr_rd && (i_rs1_addr_q == i_mem_rd_addr);
    assign rs2_mem_hit = i_mem_valid && i_mem_wr_rd && (i_rs2_addr_q == i_mem_rd_addr);
    assign rs1_wb_hit  = i_wb_valid && i_wb_wr_rd && (i_rs1_addr_q == i_wb_rd_addr);
    assign rs2_wb_hit  = i_wb_valid && i_wb_wr_rd && (i_rs2_addr_q == i_wb_rd_addr);

    always_comb begin
        o_rs1 = i_rs1_orig;  // default is the register file value
        o_rs2 = i_rs2_orig;
        o_alu_force_stall = 1'b0;

        if (rs1_mem_hit) begin
            o_rs1 = i_mem_rd;  // youngest producer wins
            if (!i_mem_rd_valid) o_alu_force_stall = 1'b1;  // load datum not here yet
        end else if (rs1_wb_hit) begin
            o_rs1 = i_wb_rd;
        end

        if (rs2_mem_hit) begin
            o_rs2 = i_mem_rd;
            if (!i_mem_rd_valid) o_alu_force_stall = 1'b1;
        end else if (rs2_wb_hit) begin
            o_rs2 = i_wb_rd;
        end

        if (i_rs1_addr_q == '0) o_rs1 = '0;  // x0 is hardwired
        if (i_rs2_addr_q == '0) o_rs2 = '0;
    end

    // a stall only ends once its load has moved on to writeback
    a_stall_ends_in_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_alu_force_stall) |-> (i_wb_valid && i_wb_wr_rd))
        else $error("forwarding: stall dropped before the load reached writeback");

endmodule

`default_nettype wire

//--- verilog/pipe_ctrl_fsm.sv
// pipeline control FSM that sequences stage enables and issue ready and owns the writeback register
`default_nettype none

module pipe_ctrl_fsm
    import rv_word_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  wire       i_alu_valid,
    input  wire       i_mem_valid,
    input  wire       i_mem_wr_rd,
    input  wire       i_mem_rd_valid,
    input  reg_addr_t i_mem_rd_addr,
    input  word_t     i_mem_rd,
    input  wire       i_alu_force_stall,
    input  wire       i_lat_done,
    output logic      o_alu_ce,
    output logic      o_mem_ce,
    output logic      o_lat_start,
    output logic      o_issue_ready,
    output logic      o_wb_valid,         // one-cycle writeback pulse
    output logic      o_wb_wr_rd,         // doubles as register file write enable
    output reg_addr_t o_wb_rd_addr,
    output word_t     o_wb_rd
);

    ctrl_state_e state_q, state_d;
    logic        load_in_mem;  // load parked in memory access
    logic        dep_stall;    // live instruction needs that load

    assign load_in_mem = i_mem_valid && !i_mem_rd_valid;
    assign dep_stall   = i_alu_valid && i_alu_force_stall;
    assign o_issue_ready = o_alu_ce;  // issue lands only when the ALU stage advances

    always_comb begin
        state_d     = state_q;
        o_alu_ce    = 1'b0;
        o_mem_ce    = 1'b0;
        o_lat_start = 1'b0;
        case (state_q)
            ST_RESET: state_d = ST_RUN;
            ST_RUN: begin
                if (load_in_mem) begin
                    o_lat_start = 1'b1;  // freeze everything and start counting
                    state_d     = ST_LOAD_WAIT;
                end else begin
                    o_alu_ce = 1'b1;
                    o_mem_ce = 1'b1;
                end
            end
            ST_LOAD_WAIT: begin
                if (i_lat_done && dep_stall) begin
                    state_d = ST_HAZARD;  // consumer waits, load goes first
                end else if (i_lat_done) begin
                    o_alu_ce = 1'b1;
                    o_mem_ce = 1'b1;
                    state_d  = ST_RUN;
                end
            end
            ST_HAZARD: begin
                o_mem_ce = 1'b1;  // load to writeback, ALU stage keeps its instruction
                state_d  = ST_RUN;
            end
            default: state_d = ST_RESET;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= ST_RESET;
            o_wb_valid <= 1'b0;
            o_wb_wr_rd <= 1'b0;
        end else begin
            state_q    <= state_d;
            o_wb_valid <= o_mem_ce && i_mem_valid;
            o_wb_wr_rd <= o_mem_ce && i_mem_valid && i_mem_wr_rd;
        end
    end

    // everything reaching writeback is final, a load datum is valid from here on
    always_ff @(posedge i_clk) begin
        if (o_mem_ce) begin
            o_wb_rd_addr <= i_mem_rd_addr;
            o_wb_rd      <= i_mem_rd;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipe_ctrl_pkg.sv
// operation and control-state encodings, imported by blocks that decode ops or run the FSM
`default_nettype none

package pipe_ctrl_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,  // rd = rs1 + rs2
        OP_SUB  = 3'd1,  // rd = rs1 - rs2
        OP_XOR  = 3'd2,  // rd = rs1 ^ rs2
        OP_AND  = 3'd3,  // rd = rs1 & rs2
        OP_LOAD = 3'd4   // rd = load datum, valid only at writeback
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_RESET     = 2'd0,  // one idle cycle out of reset
        ST_RUN       = 2'd1,  // all stages advance
        ST_LOAD_WAIT = 2'd2,  // load parked in memory access, timer running
        ST_HAZARD    = 2'd3   // drain memory access, ALU stage holds
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/rv_word_pkg.sv
// data-path vector types shared by every pipeline block, imported in each module header
`default_nettype none

`include "pipe_macros.svh"

package rv_word_pkg;

    // operand and result values
    typedef logic [`PIPE_XLEN-1:0] word_t;

    // register file index, address zero is hardwired to zero
    typedef logic [`PIPE_REG_AW-1:0] reg_addr_t;

    // load latency counter, 3 bits cover latencies up to 7
    typedef logic [2:0] lat_cnt_t;

endpackage

`default_nettype wire
